//--- include/tex_config.svh
`ifndef TEX_CONFIG_SVH
`define TEX_CONFIG_SVH

//////////////////////////////
// warp shape
//////////////////////////////

// lanes per warp.
`define TEX_NUM_THREADS 4

// width of the warp id.
`define TEX_NW_BITS 2

// width of the destination register index.
`define TEX_NR_BITS 5

//////////////////////////////
// filtering
//////////////////////////////

// per-lane u and v width; only the low TEX_BLEND_FRAC bits take part in blending.
`define TEX_COORD_BITS 16

`define TEX_BLEND_FRAC 8

// entries in the response queue.
`define TEX_QUEUE_DEPTH 2

`endif

//--- source/tex_pkg.sv
package tex_pkg;

    `include "tex_config.svh"

    typedef enum logic {
        filter_point    = 1'b0,
        filter_bilinear = 1'b1
    } tex_filter_e;

    typedef enum logic [2:0] {
        fmt_r8g8b8a8 = 3'd0,
        fmt_r5g6b5   = 3'd1,
        fmt_r4g4b4a4 = 3'd2,
        fmt_l8       = 3'd3,
        fmt_a8       = 3'd4,
        fmt_l8a8     = 3'd5
    } tex_format_e;

    // red sits in the low byte, alpha in the top byte.
    typedef struct packed {
        logic [7:0] a;
        logic [7:0] b;
        logic [7:0] g;
        logic [7:0] r;
    } tex_color_t;

    typedef logic [`TEX_NW_BITS-1:0] tex_wid_t;

    typedef logic [`TEX_NR_BITS-1:0] tex_rd_t;

    typedef logic [31:0] tex_pc_t;

endpackage

//--- source/tex_format.sv
module tex_format (
    input  tex_pkg::tex_format_e       format,
    input  logic [3:0][31:0]           texels,
    output tex_pkg::tex_color_t [3:0]  colors
);

    import tex_pkg::*;

    //////////////////////////////
    // field widening
    //////////////////////////////

    function automatic logic [7:0] widen5(input logic [4:0] x);
        return {x, x[4:2]}; // top bits refill the low end.
    endfunction

    function automatic logic [7:0] widen6(input logic [5:0] x);
        return {x, x[5:4]};
    endfunction

    function automatic logic [7:0] widen4(input logic [3:0] x);
        return {x, x};
    endfunction

    //////////////////////////////
    // per-texel decode
    //////////////////////////////

    function automatic tex_color_t decode(input tex_format_e fmt, input logic [31:0] raw);
        tex_color_t c;
        c = tex_color_t'(32'hff00_0000); // absent colour is 0, absent alpha is opaque.
        case (fmt)
            fmt_r8g8b8a8: begin
                c = tex_color_t'(raw);
            end
            fmt_r5g6b5: begin
                c.r = widen5(raw[15:11]); // red in the high bits of the half word.
                c.g = widen6(raw[10:5]);
                c.b = widen5(raw[4:0]);
            end
            fmt_r4g4b4a4: begin
                c.r = widen4(raw[15:12]);
                c.g = widen4(raw[11:8]);
                c.b = widen4(raw[7:4]);
                c.a = widen4(raw[3:0]);
            end
            fmt_l8: begin
                c.r = raw[7:0]; // luminance feeds all three colour channels.
                c.g = raw[7:0];
                c.b = raw[7:0];
            end
            fmt_a8: begin
                c.a = raw[7:0];
            end
            fmt_l8a8: begin
                c.r = raw[7:0];
                c.g = raw[7:0];
                c.b = raw[7:0];
                c.a = raw[15:8];
            end
            default: begin
                // unknown codes keep the opaque black start value.
            end
        endcase
        return c;
    endfunction

    always_comb begin
        for (int i = 0; i < 4; i++) begin
            colors[i] = decode(format, texels[i]);
        end
    end

endmodule

//--- source/tex_bilerp.sv
`include "tex_config.svh"

module tex_bilerp (
    input  logic [`TEX_BLEND_FRAC-1:0]  blend_u,
    input  logic [`TEX_BLEND_FRAC-1:0]  blend_v,
    input  tex_pkg::tex_color_t [3:0]   texels,
    output tex_pkg::tex_color_t         color
);

    localparam int FRAC = `TEX_BLEND_FRAC;
    localparam int SUMW = 8 + FRAC;
    localparam logic [FRAC:0] ONE = 1 << FRAC;

    logic [3:0][3:0][7:0] chan; // texel, then channel.
    logic [3:0][7:0]      top_row;
    logic [3:0][7:0]      bot_row;
    logic [3:0][7:0]      mixed;

    //////////////////////////////
    // linear blend
    //////////////////////////////

    // weights sum to ONE, so the sum never overflows SUMW bits.
    function automatic logic [7:0] lerp(
        input logic [7:0]      a,
        input logic [7:0]      b,
        input logic [FRAC-1:0] f
    );
        logic [FRAC:0]   inv_f;
        logic [SUMW-1:0] sum;
        inv_f = ONE - {1'b0, f};
        sum   = a * inv_f + b * f;
        return sum[SUMW-1:FRAC];
    endfunction

    assign chan = texels;

    //////////////////////////////
    // two rows in u, then v
    //////////////////////////////

    always_comb begin
        for (int c = 0; c < 4; c++) begin
            top_row[c] = lerp(chan[0][c], chan[1][c], blend_u); // texels 0 and 1.
            bot_row[c] = lerp(chan[2][c], chan[3][c], blend_u); // texels 2 and 3.
            mixed[c]   = lerp(top_row[c], bot_row[c], blend_v);
        end
    end

    assign color = mixed;

endmodule

//--- source/tex_sampler.sv
`include "tex_config.svh"

module tex_sampler (
    input  logic                                               clk,
    input  logic                                               rst_n,

    input  logic                                               req_valid,
    input  tex_pkg::tex_wid_t                                  req_wid,
    input  logic [`TEX_NUM_THREADS-1:0]                        req_tmask,
    input  tex_pkg::tex_pc_t                                   req_pc,
    input  tex_pkg::tex_rd_t                                   req_rd,
    input  logic                                               req_wb,
    input  tex_pkg::tex_filter_e                               req_filter,
    input  tex_pkg::tex_format_e                               req_format,
    input  logic [`TEX_NUM_THREADS-1:0][`TEX_COORD_BITS-1:0]   req_u,
    input  logic [`TEX_NUM_THREADS-1:0][`TEX_COORD_BITS-1:0]   req_v,
    input  logic [`TEX_NUM_THREADS-1:0][3:0][31:0]             req_texels,
    output logic                                               req_ready,

    output logic                                               smp_valid,
    output tex_pkg::tex_wid_t                                  smp_wid,
    output logic [`TEX_NUM_THREADS-1:0]                        smp_tmask,
    output tex_pkg::tex_pc_t                                   smp_pc,
    output tex_pkg::tex_rd_t                                   smp_rd,
    output logic                                               smp_wb,
    output tex_pkg::tex_color_t [`TEX_NUM_THREADS-1:0]         smp_data,
    input  logic                                               smp_ready
);

    import tex_pkg::*;

    tex_color_t [`TEX_NUM_THREADS-1:0] req_data;

    //////////////////////////////
    // per-lane datapath
    //////////////////////////////

    for (genvar i = 0; i < `TEX_NUM_THREADS; i++) begin : g_lane
        tex_color_t [3:0] lane_texels;
        tex_color_t       lane_bilerp;

        tex_format format_i (
            .format (req_format),
            .texels (req_texels[i]),
            .colors (lane_texels)
        );

        tex_bilerp bilerp_i (
            .blend_u (req_u[i][`TEX_BLEND_FRAC-1:0]),
            .blend_v (req_v[i][`TEX_BLEND_FRAC-1:0]),
            .texels  (lane_texels),
            .color   (lane_bilerp)
        );

        assign req_data[i] = (req_filter == filter_point) ? lane_texels[0] : lane_bilerp;
    end

    //////////////////////////////
    // output register
    //////////////////////////////

    assign req_ready = smp_ready; // the register advances exactly when the queue has room.

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            smp_valid <= 1'b0;
        end else if (smp_ready) begin
            smp_valid <= req_valid; // bubbles load too.
        end
    end

    always_ff @(posedge clk) begin
        if (smp_ready) begin
            smp_wid   <= req_wid;
            smp_tmask <= req_tmask;
            smp_pc    <= req_pc;
            smp_rd    <= req_rd;
            smp_wb    <= req_wb;
            smp_data  <= req_data;
        end
    end

endmodule

//--- source/tex_rsp_queue.sv
`include "tex_config.svh"

module tex_rsp_queue #(
    parameter int DEPTH = 2
) (
    input  logic                                         clk,
    input  logic                                         rst_n,

    input  logic                                         in_valid,
    output logic                                         in_ready,
    input  tex_pkg::tex_wid_t                            in_wid,
    input  logic [`TEX_NUM_THREADS-1:0]                  in_tmask,
    input  tex_pkg::tex_pc_t                             in_pc,
    input  tex_pkg::tex_rd_t                             in_rd,
    input  logic                                         in_wb,
    input  tex_pkg::tex_color_t [`TEX_NUM_THREADS-1:0]   in_data,

    output logic                                         out_valid,
    input  logic                                         out_ready,
    output tex_pkg::tex_wid_t                            out_wid,
    output logic [`TEX_NUM_THREADS-1:0]                  out_tmask,
    output tex_pkg::tex_pc_t                             out_pc,
    output tex_pkg::tex_rd_t                             out_rd,
    output logic                                         out_wb,
    output tex_pkg::tex_color_t [`TEX_NUM_THREADS-1:0]   out_data
);

    import tex_pkg::*;

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    tex_wid_t                          wid_mem   [DEPTH];
    logic [`TEX_NUM_THREADS-1:0]       tmask_mem [DEPTH];
    tex_pc_t                           pc_mem    [DEPTH];
    tex_rd_t                           rd_mem    [DEPTH];
    logic                              wb_mem    [DEPTH];
    tex_color_t [`TEX_NUM_THREADS-1:0] data_mem  [DEPTH];

    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic             push;
    logic             pop;

    function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] p);
        return (p == PTR_W'(DEPTH - 1)) ? '0 : p + 1'b1;
    endfunction

    assign in_ready  = (count != CNT_W'(DEPTH)); // a full queue refuses, even while popping.
    assign out_valid = (count != '0);
    assign push      = in_valid && in_ready;
    assign pop       = out_valid && out_ready;

    //////////////////////////////
    // pointers and count
    //////////////////////////////

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) wr_ptr <= next_ptr(wr_ptr);
            if (pop) rd_ptr <= next_ptr(rd_ptr);
            count <= count + CNT_W'(push) - CNT_W'(pop);
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            wid_mem[wr_ptr]   <= in_wid;
            tmask_mem[wr_ptr] <= in_tmask;
            pc_mem[wr_ptr]    <= in_pc;
            rd_mem[wr_ptr]    <= in_rd;
            wb_mem[wr_ptr]    <= in_wb;
            data_mem[wr_ptr]  <= in_data;
        end
    end

    assign out_wid   = wid_mem[rd_ptr]; // head entry, stable until popped.
    assign out_tmask = tmask_mem[rd_ptr];
    assign out_pc    = pc_mem[rd_ptr];
    assign out_rd    = rd_mem[rd_ptr];
    assign out_wb    = wb_mem[rd_ptr];
    assign out_data  = data_mem[rd_ptr];

endmodule

//--- source/tex_unit.sv
`include "tex_config.svh"

module tex_unit (
    input  logic                                               clk,
    input  logic                                               rst_n,

    input  logic                                               req_valid,
    output logic                                               req_ready,
    input  tex_pkg::tex_wid_t                                  req_wid,
    input  logic [`TEX_NUM_THREADS-1:0]                        req_tmask,
    input  tex_pkg::tex_pc_t                                   req_pc,
    input  tex_pkg::tex_rd_t                                   req_rd,
    input  logic                                               req_wb,
    input  tex_pkg::tex_filter_e                               req_filter,
    input  tex_pkg::tex_format_e                               req_format,
    input  logic [`TEX_NUM_THREADS-1:0][`TEX_COORD_BITS-1:0]   req_u,
    input  logic [`TEX_NUM_THREADS-1:0][`TEX_COORD_BITS-1:0]   req_v,
    input  logic [`TEX_NUM_THREADS-1:0][3:0][31:0]             req_texels,

    output logic                                               rsp_valid,
    input  logic                                               rsp_ready,
    output tex_pkg::tex_wid_t                                  rsp_wid,
    output logic [`TEX_NUM_THREADS-1:0]                        rsp_tmask,
    output tex_pkg::tex_pc_t                                   rsp_pc,
    output tex_pkg::tex_rd_t                                   rsp_rd,
    output logic                                               rsp_wb,
    output tex_pkg::tex_color_t [`TEX_NUM_THREADS-1:0]         rsp_data
);

    import tex_pkg::*;

    logic                              smp_valid;
    logic                              smp_ready;
    tex_wid_t                          smp_wid;
    logic [`TEX_NUM_THREADS-1:0]       smp_tmask;
    tex_pc_t                           smp_pc;
    tex_rd_t                           smp_rd;
    logic                              smp_wb;
    tex_color_t [`TEX_NUM_THREADS-1:0] smp_data;

    tex_sampler sampler_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .req_valid  (req_valid),
        .req_wid    (req_wid),
        .req_tmask  (req_tmask),
        .req_pc     (req_pc),
        .req_rd     (req_rd),
        .req_wb     (req_wb),
        .req_filter (req_filter),
        .req_format (req_format),
        .req_u      (req_u),
        .req_v      (req_v),
        .req_texels (req_texels),
        .req_ready  (req_ready),
        .smp_valid  (smp_valid),
        .smp_wid    (smp_wid),
        .smp_tmask  (smp_tmask),
        .smp_pc     (smp_pc),
        .smp_rd     (smp_rd),
        .smp_wb     (smp_wb),
        .smp_data   (smp_data),
        .smp_ready  (smp_ready)
    );

    tex_rsp_queue #(
        .DEPTH (`TEX_QUEUE_DEPTH)
    ) rsp_queue_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (smp_valid),
        .in_ready  (smp_ready),
        .in_wid    (smp_wid),
        .in_tmask  (smp_tmask),
        .in_pc     (smp_pc),
        .in_rd     (smp_rd),
        .in_wb     (smp_wb),
        .in_data   (smp_data),
        .out_valid (rsp_valid),
        .out_ready (rsp_ready),
        .out_wid   (rsp_wid),
        .out_tmask (rsp_tmask),
        .out_pc    (rsp_pc),
        .out_rd    (rsp_rd),
        .out_wb    (rsp_wb),
        .out_data  (rsp_data)
    );

endmodule

//--- verification/tex_unit_tb.sv
`include "tex_config.svh"

module tex_unit_tb;

    timeunit 1ns;
    timeprecision 1ps;

    import tex_pkg::*;

    localparam int MAX_PAT = 32;
    localparam int LANES = `TEX_NUM_THREADS;

    logic clk;
    logic rst_n;
    logic req_valid;
    logic req_ready;
    tex_wid_t req_wid;
    logic [LANES-1:0] req_tmask;
    tex_pc_t req_pc;
    tex_rd_t req_rd;
    logic req_wb;
    tex_filter_e req_filter;
    tex_format_e req_format;
    logic [LANES-1:0][`TEX_COORD_BITS-1:0] req_u;
    logic [LANES-1:0][`TEX_COORD_BITS-1:0] req_v;
    logic [LANES-1:0][3:0][31:0] req_texels;
    logic rsp_valid;
    logic rsp_ready;
    tex_wid_t rsp_wid;
    logic [LANES-1:0] rsp_tmask;
    tex_pc_t rsp_pc;
    tex_rd_t rsp_rd;
    logic rsp_wb;
    tex_color_t [LANES-1:0] rsp_data;

    // requests and expected colours as read from the pattern file.
    int num_pat;
    tex_wid_t pat_wid [MAX_PAT];
    logic [LANES-1:0] pat_tmask [MAX_PAT];
    tex_pc_t pat_pc [MAX_PAT];
    tex_rd_t pat_rd [MAX_PAT];
    logic pat_wb [MAX_PAT];
    tex_filter_e pat_filter [MAX_PAT];
    tex_format_e pat_format [MAX_PAT];
    logic [LANES-1:0][`TEX_COORD_BITS-1:0] pat_u [MAX_PAT];
    logic [LANES-1:0][`TEX_COORD_BITS-1:0] pat_v [MAX_PAT];
    logic [LANES-1:0][3:0][31:0] pat_tex [MAX_PAT];
    tex_color_t [LANES-1:0] pat_exp [MAX_PAT];

    int exp_idx [$];
    time exp_time [$];
    bit exp_fast [$];
    int accepted_cnt;
    int delivered_cnt;
    bit fast_phase;
    integer seed;

    tex_unit tex_unit_i (.*);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    //////////////////////////////
    // checks
    //////////////////////////////

    task automatic end_with_failure();
        $display("Testbench failed");
        $fatal(1);
    endtask

    task automatic abort_run(input string msg);
        $display("%s", msg);
        end_with_failure();
    endtask

    task automatic check_color(input string name, input int lane,
                               input tex_color_t exp, input tex_color_t act);
        if (act !== exp) begin
            $display("** Error %s lane %0d: expected %h, actual %h", name, lane, exp, act);
            end_with_failure();
        end
    endtask

    task automatic check_tag(input string name,
                             input tex_wid_t exp_wid, input tex_wid_t act_wid,
                             input tex_rd_t exp_rd, input tex_rd_t act_rd,
                             input tex_pc_t exp_pc, input tex_pc_t act_pc,
                             input logic [LANES-1:0] exp_mask, input logic [LANES-1:0] act_mask,
                             input logic exp_wb, input logic act_wb);
        string exp_s;
        string act_s;
        if ({act_wid, act_rd, act_pc, act_mask, act_wb} !==
            {exp_wid, exp_rd, exp_pc, exp_mask, exp_wb}) begin
            exp_s = $sformatf("wid %h rd %h pc %h mask %h wb %b",
                              exp_wid, exp_rd, exp_pc, exp_mask, exp_wb);
            act_s = $sformatf("wid %h rd %h pc %h mask %h wb %b",
                              act_wid, act_rd, act_pc, act_mask, act_wb);
            $display("** Error %s tag: expected %s, actual %s", name, exp_s, act_s);
            end_with_failure();
        end
    endtask

    task automatic check_latency(input string name, input time exp, input time act);
        if (act != exp) begin
            $display("** Error %s latency: expected response at %0t, actual %0t", name, exp, act);
            end_with_failure();
        end
    endtask

    //////////////////////////////
    // pattern file
    //////////////////////////////

    task automatic read_patterns();
        int fd;
        int cnt;
        int lane;
        string line;
        logic [31:0] f0, f1, f2, f3, f4, f5, f6;
        fd = $fopen("verification/tex_patterns.txt", "r");
        if (fd == 0) abort_run("cannot open verification/tex_patterns.txt");
        num_pat = 0;
        lane = 0;
        while ($fgets(line, fd)) begin
            if (line.len() < 2 || line.getc(0) == "#") continue;
            if (line.getc(0) == "R") begin
                cnt = $sscanf(line, "R %h %h %h %h %h %h %h", f0, f1, f2, f3, f4, f5, f6);
                if (cnt != 7 || num_pat >= MAX_PAT) abort_run("bad request line in pattern file");
                pat_wid[num_pat] = f0[`TEX_NW_BITS-1:0];
                pat_tmask[num_pat] = f1[LANES-1:0];
                pat_pc[num_pat] = f2;
                pat_rd[num_pat] = f3[`TEX_NR_BITS-1:0];
                pat_wb[num_pat] = f4[0];
                pat_filter[num_pat] = tex_filter_e'(f5[0]);
                pat_format[num_pat] = tex_format_e'(f6[2:0]);
                num_pat++;
                lane = 0;
            end else begin
                cnt = $sscanf(line, "L %h %h %h %h %h %h %h", f0, f1, f2, f3, f4, f5, f6);
                if (cnt != 7 || num_pat == 0 || lane >= LANES) begin
                    abort_run("bad lane line in pattern file");
                end
                pat_u[num_pat-1][lane] = f0[`TEX_COORD_BITS-1:0];
                pat_v[num_pat-1][lane] = f1[`TEX_COORD_BITS-1:0];
                pat_tex[num_pat-1][lane] = {f5, f4, f3, f2}; // texel 0 in the low word.
                pat_exp[num_pat-1][lane] = tex_color_t'(f6);
                lane++;
            end
        end
        $fclose(fd);
        if (num_pat == 0) abort_run("pattern file holds no requests");
    endtask

    //////////////////////////////
    // driver
    //////////////////////////////

    // called on a rising edge; returns on the edge where the request is taken.
    task automatic send_request(input int idx);
        int waited;
        req_valid <= 1'b1;
        req_wid <= pat_wid[idx];
        req_tmask <= pat_tmask[idx];
        req_pc <= pat_pc[idx];
        req_rd <= pat_rd[idx];
        req_wb <= pat_wb[idx];
        req_filter <= pat_filter[idx];
        req_format <= pat_format[idx];
        req_u <= pat_u[idx];
        req_v <= pat_v[idx];
        req_texels <= pat_tex[idx];
        waited = 0;
        @(posedge clk);
        while (!req_ready) begin
            waited++;
            if (waited > 1000) abort_run("timeout while waiting for req_ready");
            @(posedge clk);
        end
        exp_idx.push_back(idx);
        exp_time.push_back($time);
        exp_fast.push_back(fast_phase);
        accepted_cnt++;
    endtask

    task automatic send_all();
        for (int i = 0; i < num_pat; i++) begin
            send_request(i);
        end
        req_valid <= 1'b0;
    endtask

    task automatic wait_drained();
        int waited;
        waited = 0;
        while (delivered_cnt != accepted_cnt) begin
            waited++;
            if (waited > 1000) abort_run("timeout while waiting for all responses");
            @(posedge clk);
        end
    endtask

    //////////////////////////////
    // monitor
    //////////////////////////////

    initial begin
        int idx;
        time t_acc;
        bit fast;
        string name;
        bit held;
        bit fast_seen;
        time last_fast;
        tex_wid_t h_wid;
        logic [LANES-1:0] h_tmask;
        tex_pc_t h_pc;
        tex_rd_t h_rd;
        logic h_wb;
        tex_color_t [LANES-1:0] h_data;
        held = 1'b0;
        fast_seen = 1'b0;
        last_fast = 0;
        forever begin
            @(posedge clk);
            if (held && (rsp_valid !== 1'b1 ||
                {rsp_wid, rsp_tmask, rsp_pc, rsp_rd, rsp_wb, rsp_data} !==
                {h_wid, h_tmask, h_pc, h_rd, h_wb, h_data})) begin
                abort_run("held response changed while rsp_ready was low");
            end
            if (rst_n && rsp_valid && rsp_ready) begin
                if (exp_idx.size() == 0) begin
                    abort_run("response arrived with no request outstanding");
                end
                idx = exp_idx.pop_front();
                t_acc = exp_time.pop_front();
                fast = exp_fast.pop_front();
                name = $sformatf("%s req%0d", fast ? "throughput" : "backpressure", idx);
                check_tag(name, pat_wid[idx], rsp_wid, pat_rd[idx], rsp_rd,
                          pat_pc[idx], rsp_pc, pat_tmask[idx], rsp_tmask, pat_wb[idx], rsp_wb);
                for (int l = 0; l < LANES; l++) begin
                    check_color(name, l, pat_exp[idx][l], rsp_data[l]);
                end
                if (fast) begin
                    check_latency(name, t_acc + 20, $time); // two cycles of 10 ns.
                    if (fast_seen) check_latency(name, last_fast + 10, $time); // one per cycle.
                    fast_seen = 1'b1;
                    last_fast = $time;
                end
                delivered_cnt++;
            end
            held = rst_n && rsp_valid && !rsp_ready;
            h_wid = rsp_wid;
            h_tmask = rsp_tmask;
            h_pc = rsp_pc;
            h_rd = rsp_rd;
            h_wb = rsp_wb;
            h_data = rsp_data;
            if (rst_n) rsp_ready <= fast_phase ? 1'b1 : (($random(seed) % 3) != 0);
        end
    end

    initial begin
        forever begin
            @(negedge clk);
            if (accepted_cnt - delivered_cnt > 3) abort_run("more than three requests in flight");
        end
    end

    //////////////////////////////
    // main sequence
    //////////////////////////////

    initial begin
        seed = 32'h1f21;
        accepted_cnt = 0;
        delivered_cnt = 0;
        fast_phase = 1'b0;
        rst_n = 1'b0;
        req_valid = 1'b0;
        req_wid = '0;
        req_tmask = '0;
        req_pc = '0;
        req_rd = '0;
        req_wb = 1'b0;
        req_filter = filter_point;
        req_format = fmt_r8g8b8a8;
        req_u = '0;
        req_v = '0;
        req_texels = '0;
        rsp_ready = 1'b1;
        read_patterns();
        repeat (4) @(posedge clk);
        rst_n <= 1'b1;
        repeat (2) begin
            @(posedge clk);
            if (rsp_valid !== 1'b0 || req_ready !== 1'b1) begin
                abort_run("wrong handshake state after reset");
            end
        end
        send_all(); // random back-pressure from the monitor.
        wait_drained();
        fast_phase = 1'b1;
        repeat (2) @(posedge clk);
        send_all();
        wait_drained();
        $display("Testbench passed");
        $finish;
    end

endmodule

//--- src.f
+incdir+include
source/tex_pkg.sv
source/tex_format.sv
source/tex_bilerp.sv
source/tex_sampler.sv
source/tex_rsp_queue.sv
source/tex_unit.sv
verification/tex_unit_tb.sv

//--- Makefile
SOURCES := $(wildcard source/*.sv include/*.svh verification/*.sv)

.PHONY: all run clean

all: obj_dir/Vtex_unit_tb

# rebuilt only when a source, header or the file list changes
obj_dir/Vtex_unit_tb: src.f $(SOURCES)
	verilator --binary --timing -f src.f --top-module tex_unit_tb -Mdir obj_dir -o Vtex_unit_tb

# the log decides pass or fail
run: obj_dir/Vtex_unit_tb verification/tex_patterns.txt
	./obj_dir/Vtex_unit_tb | tee sim.log
	grep -q "Testbench passed" sim.log

clean:
	rm -rf obj_dir sim.log

//--- verification/tex_patterns.txt
# R wid tmask pc rd wb filter format, then four L lines: u v texel0 texel1 texel2 texel3 expected
# all hex; filter 0 point 1 bilinear; format 0 rgba8 1 r5g6b5 2 rgba4 3 l8 4 a8 5 l8a8
R 0 f 00001000 01 1 0 0
L 0000 0000 11223344 aaaaaaaa bbbbbbbb cccccccc 11223344
L 00ff 00ff deadbeef 00000000 ffffffff 12345678 deadbeef
L 0080 0040 00000000 ffffffff ffffffff ffffffff 00000000
L 1234 5678 ff00ff00 0f0f0f0f f0f0f0f0 00ff00ff ff00ff00
R 1 a 00001004 02 0 0 1
L 0000 0000 0000f800 00000000 00000000 00000000 ff0000ff
L 0000 0000 000007e0 00000000 00000000 00000000 ff00ff00
L 0000 0000 0000001f 00000000 00000000 00000000 ffff0000
L 0000 0000 abcd1234 00000000 00000000 00000000 ffa54510
R 2 5 00001008 1f 1 0 2
L 0000 0000 0000f00f 00000000 00000000 00000000 ff0000ff
L 0000 0000 00001234 00000000 00000000 00000000 44332211
L 0000 0000 ffffabcd 00000000 00000000 00000000 ddccbbaa
L 0000 0000 00000000 ffffffff ffffffff ffffffff 00000000
R 3 3 0000100c 07 0 0 3
L 0000 0000 00000080 00000000 00000000 00000000 ff808080
L 0000 0000 ffffff00 00000000 00000000 00000000 ff000000
L 0000 0000 0000005a 00000000 00000000 00000000 ff5a5a5a
L 0000 0000 12345678 00000000 00000000 00000000 ff787878
R 0 c 00001010 10 1 0 4
L 0000 0000 00000080 00000000 00000000 00000000 80000000
L 0000 0000 000000ff 00000000 00000000 00000000 ff000000
L 0000 0000 0000003c 00000000 00000000 00000000 3c000000
L 0000 0000 00001200 00000000 00000000 00000000 00000000
R 1 0 00001014 0a 0 0 5
L 0000 0000 00008040 00000000 00000000 00000000 80404040
L 0000 0000 000000ff 00000000 00000000 00000000 00ffffff
L 0000 0000 0000ff00 00000000 00000000 00000000 ff000000
L 0000 0000 abcd1234 00000000 00000000 00000000 12343434
R 2 f 00001018 15 1 1 0
L 0000 0000 11223344 55667788 99aabbcc ddeeff00 11223344
L 0000 00ff 00000000 ffffffff 80402010 12345678 7f3f1f0f
L 0080 0080 00000000 ffffffff 00000000 ffffffff 7f7f7f7f
L 1240 abc0 10101010 50505050 90909090 d0d0d0d0 80808080
R 3 9 0000101c 1e 1 1 1
L 0000 0000 0000f800 0000ffff 0000ffff 0000ffff ff0000ff
L 00ff 0000 00000000 0000ffff 00000000 00000000 fffefefe
L 0000 0000 000007e0 00000000 00000000 00000000 ff00ff00
L 0080 0080 0000f800 0000f800 0000f800 0000f800 ff0000ff
